//--- hw/runner_pkg.sv
`default_nettype none

package runner_pkg;

  // screen coordinate, same width as the painter's write_x / write_y
  typedef logic [11:0] coord_t;
  // vertical speed in px per step, positive is upward
  typedef logic signed [7:0] vel_t;
  // painter sprite selector
  typedef logic [1:0] sprite_kind_t;
  // steps survived
  typedef logic [15:0] score_t;
  // lfsr word, same width as the board's rng_data
  typedef logic [10:0] seed_t;

  // sprite kinds, none marks an empty slot
  localparam sprite_kind_t KIND_NONE = 2'd0;
  localparam sprite_kind_t KIND_RUNNER = 2'd1;
  localparam sprite_kind_t KIND_RUNNER_DUCK = 2'd2;
  localparam sprite_kind_t KIND_CACTUS = 2'd3;

  typedef enum logic [1:0] {
    game_idle = 2'd0,
    game_run  = 2'd1,
    game_over = 2'd2
  } game_state_t;

  // y of the runner's feet and of every cactus base
  localparam coord_t GROUND_Y = 12'd200;
  localparam coord_t RUNNER_X = 12'd40;
  localparam coord_t RUNNER_W = 12'd16;
  localparam coord_t RUNNER_H = 12'd24;
  localparam coord_t DUCK_H = 12'd12;
  localparam coord_t CACTUS_W = 12'd12;
  localparam coord_t CACTUS_H = 12'd20;
  // new obstacles enter at the right edge
  localparam coord_t SCREEN_W = 12'd640;
  localparam vel_t JUMP_V = 8'sd12;
  localparam vel_t GRAVITY = 8'sd1;
  // shortest spawn spacing, in steps
  localparam int MIN_GAP = 24;

endpackage

`default_nettype wire

//--- hw/runner_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module runner_ctrl (
  input  logic                     clk_33m,
  input  logic                     arst_n,
  input  logic                     jumping,
  input  logic                     hit,
  input  logic                     sprite_ready,
  output logic                     step,
  output logic                     list_load,
  output logic                     sprite_valid,
  output logic                     restart,
  output runner_pkg::game_state_t  state,
  output runner_pkg::score_t       score
);

  // low for the first cycle out of reset, forces the initial list load
  logic booted;
  logic accept;

  // painter takes the current list
  assign accept = sprite_valid && sprite_ready;

  // step sequencing
  // accept -> step -> list_load -> valid, one step in flight at most
  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      booted       <= 1'b0;
      step         <= 1'b0;
      restart      <= 1'b0;
      list_load    <= 1'b0;
      sprite_valid <= 1'b0;
    end else begin
      booted <= 1'b1;
      step   <= accept;
      // jump seen at the accept while stopped starts a new run
      restart <= accept && (state != runner_pkg::game_run) && jumping;
      // datapath settles one cycle after the step
      list_load <= step || !booted;
      if (list_load) begin
        sprite_valid <= 1'b1;
      end else if (accept) begin
        sprite_valid <= 1'b0;
      end
    end
  end

  // game state machine
  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      state <= runner_pkg::game_idle;
    end else begin
      case (state)
        runner_pkg::game_run: begin
          // the list just shown had an overlap, freeze before the step
          if (accept && hit) begin
            state <= runner_pkg::game_over;
          end
        end
        runner_pkg::game_idle,
        runner_pkg::game_over: begin
          if (restart) begin
            state <= runner_pkg::game_run;
          end
        end
        default: begin
          state <= runner_pkg::game_idle;
        end
      endcase
    end
  end

  // score counts steps taken while running
  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      score <= '0;
    end else if (restart) begin
      score <= '0;
    end else if (step && (state == runner_pkg::game_run)) begin
      score <= score + 16'd1;
    end
  end

endmodule

`default_nettype wire

//--- hw/player_physics.sv
`timescale 1ns/1ps
`default_nettype none

module player_physics (
  input  logic               clk_33m,
  input  logic               arst_n,
  input  logic               step,
  input  logic               running,
  input  logic               restart,
  input  logic               jumping,
  input  logic               ducking,
  output runner_pkg::coord_t runner_y,
  output logic               crouched
);

  // height of the feet above ground, zero when standing
  runner_pkg::coord_t height;
  runner_pkg::vel_t   vel;
  logic               on_ground;
  logic               moving;
  // velocity used this step, jump overrides on the ground
  runner_pkg::vel_t   v_eff;
  // signed trial height, may dip below ground
  logic signed [13:0] next_h;

  assign on_ground = (height == '0);
  // standing still unless a jump starts
  assign moving = !on_ground || jumping;

  always_comb begin
    v_eff = (on_ground && jumping) ? runner_pkg::JUMP_V : vel;
    next_h = $signed({2'b00, height}) + $signed({{6{v_eff[7]}}, v_eff});
  end

  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      height   <= '0;
      vel      <= '0;
      crouched <= 1'b0;
    end else if (restart) begin
      // new run starts standing on the ground
      height   <= '0;
      vel      <= '0;
      crouched <= 1'b0;
    end else if (step && running) begin
      if (moving) begin
        if (next_h <= 14'sd0) begin
          // landed, snap to ground
          height   <= '0;
          vel      <= '0;
          crouched <= ducking;
        end else begin
          height   <= next_h[11:0];
          vel      <= v_eff - runner_pkg::GRAVITY;
          crouched <= 1'b0;
        end
      end else begin
        // on the ground with no jump
        crouched <= ducking;
      end
    end
  end

  // feet position in screen space, y grows downward
  assign runner_y = runner_pkg::GROUND_Y - height;

endmodule

`default_nettype wire

//--- hw/obstacle_field.sv
`timescale 1ns/1ps
`default_nettype none

module obstacle_field #(
  parameter int OBSTACLE_SLOTS = 3,
  parameter int SCROLL_SPEED = 4
) (
  input  logic                                     clk_33m,
  input  logic                                     arst_n,
  input  logic                                     step,
  input  logic                                     running,
  input  logic                                     restart,
  input  logic                                     slow,
  input  runner_pkg::seed_t                        random_seed,
  output logic [OBSTACLE_SLOTS-1:0]                obst_live,
  output runner_pkg::coord_t [OBSTACLE_SLOTS-1:0]  obst_x
);

  localparam runner_pkg::coord_t SPEED = runner_pkg::coord_t'(SCROLL_SPEED);
  localparam logic [6:0] GAP_BASE = 7'(runner_pkg::MIN_GAP);

  logic [OBSTACLE_SLOTS-1:0]               live_next;
  runner_pkg::coord_t [OBSTACLE_SLOTS-1:0] x_next;
  // one-hot pick of the lowest free slot
  logic [OBSTACLE_SLOTS-1:0]               spawn_sel;
  logic                                    found;
  // toggles each step while slow, motion on the high phase
  logic                                    half_tick;
  logic                                    move;
  logic                                    spawn_now;
  logic [6:0]                              countdown;
  runner_pkg::seed_t                       lfsr;

  // slow halves the scroll rate
  assign move = !slow || half_tick;
  // countdown reaches zero with this step
  assign spawn_now = (countdown == 7'd1);

  always_comb begin
    live_next = obst_live;
    x_next    = obst_x;
    // scroll left, retire anything that would pass the edge
    for (int i = 0; i < OBSTACLE_SLOTS; i++) begin
      if (obst_live[i] && move) begin
        if (obst_x[i] < SPEED) begin
          live_next[i] = 1'b0;
        end else begin
          x_next[i] = obst_x[i] - SPEED;
        end
      end
    end
    // lowest slot still free after the scroll
    spawn_sel = '0;
    found     = 1'b0;
    for (int i = 0; i < OBSTACLE_SLOTS; i++) begin
      if (!live_next[i] && !found) begin
        spawn_sel[i] = 1'b1;
        found        = 1'b1;
      end
    end
    // new cactus enters at the right edge
    if (spawn_now && found) begin
      live_next = live_next | spawn_sel;
      for (int i = 0; i < OBSTACLE_SLOTS; i++) begin
        if (spawn_sel[i]) begin
          x_next[i] = runner_pkg::SCREEN_W;
        end
      end
    end
  end

  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      obst_live <= '0;
      obst_x    <= '0;
      half_tick <= 1'b0;
      countdown <= GAP_BASE;
      lfsr      <= 11'd1;
    end else if (restart) begin
      // empty field, fresh lfsr
      obst_live <= '0;
      obst_x    <= '0;
      half_tick <= 1'b0;
      countdown <= GAP_BASE;
      // all-zero word would lock the lfsr
      lfsr      <= (random_seed == '0) ? 11'd1 : random_seed;
    end else if (step && running) begin
      obst_live <= live_next;
      obst_x    <= x_next;
      if (slow) begin
        half_tick <= !half_tick;
      end
      if (spawn_now) begin
        // gap from the low lfsr bits, then one fibonacci shift
        countdown <= GAP_BASE + {2'b00, lfsr[4:0]};
        lfsr      <= {lfsr[9:0], lfsr[10] ^ lfsr[8]};
      end else begin
        countdown <= countdown - 7'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/collision_check.sv
`timescale 1ns/1ps
`default_nettype none

module collision_check #(
  parameter int OBSTACLE_SLOTS = 3
) (
  input  runner_pkg::coord_t                       runner_y,
  input  logic                                     crouched,
  input  logic [OBSTACLE_SLOTS-1:0]                obst_live,
  input  runner_pkg::coord_t [OBSTACLE_SLOTS-1:0]  obst_x,
  output logic                                     hit
);

  // runner box spans x [RUNNER_X, runner_right)
  localparam logic [12:0] RUNNER_RIGHT = {1'b0, runner_pkg::RUNNER_X} +
                                         {1'b0, runner_pkg::RUNNER_W};
  // cactus box spans y [CACTUS_TOP, GROUND_Y)
  localparam runner_pkg::coord_t CACTUS_TOP = runner_pkg::GROUND_Y - runner_pkg::CACTUS_H;

  runner_pkg::coord_t runner_top;
  logic               y_overlap;
  logic [12:0]        obst_right;

  always_comb begin
    // ducked box is shorter, feet stay put
    runner_top = runner_y - (crouched ? runner_pkg::DUCK_H : runner_pkg::RUNNER_H);
    // half-open intervals, touching edges do not count
    y_overlap = (runner_top < runner_pkg::GROUND_Y) && (runner_y > CACTUS_TOP);
    hit = 1'b0;
    obst_right = '0;
    for (int i = 0; i < OBSTACLE_SLOTS; i++) begin
      obst_right = {1'b0, obst_x[i]} + {1'b0, runner_pkg::CACTUS_W};
      // any live cactus whose box overlaps the runner's
      if (obst_live[i] && y_overlap &&
          ({1'b0, obst_x[i]} < RUNNER_RIGHT) &&
          (obst_right > {1'b0, runner_pkg::RUNNER_X})) begin
        hit = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/sprite_list.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_list #(
  parameter int OBSTACLE_SLOTS = 3,
  localparam int RENDER_SLOTS = OBSTACLE_SLOTS + 1
) (
  input  logic                                          clk_33m,
  input  logic                                          arst_n,
  input  logic                                          list_load,
  input  runner_pkg::coord_t                            runner_y,
  input  logic                                          crouched,
  input  logic [OBSTACLE_SLOTS-1:0]                     obst_live,
  input  runner_pkg::coord_t [OBSTACLE_SLOTS-1:0]       obst_x,
  output runner_pkg::sprite_kind_t [RENDER_SLOTS-1:0]   sprite_kind,
  output runner_pkg::coord_t [RENDER_SLOTS-1:0]         sprite_x,
  output runner_pkg::coord_t [RENDER_SLOTS-1:0]         sprite_y
);

  // cacti all stand on the ground line
  localparam runner_pkg::coord_t CACTUS_Y = runner_pkg::GROUND_Y - runner_pkg::CACTUS_H;

  always_ff @(posedge clk_33m or negedge arst_n) begin
    if (!arst_n) begin
      // standing runner, empty field
      sprite_kind[0] <= runner_pkg::KIND_RUNNER;
      sprite_x[0]    <= runner_pkg::RUNNER_X;
      sprite_y[0]    <= runner_pkg::GROUND_Y - runner_pkg::RUNNER_H;
      for (int i = 1; i < RENDER_SLOTS; i++) begin
        sprite_kind[i] <= runner_pkg::KIND_NONE;
        sprite_x[i]    <= '0;
        sprite_y[i]    <= '0;
      end
    end else if (list_load) begin
      // slot 0 is always the runner, top edge from the feet
      sprite_x[0] <= runner_pkg::RUNNER_X;
      if (crouched) begin
        sprite_kind[0] <= runner_pkg::KIND_RUNNER_DUCK;
        sprite_y[0]    <= runner_y - runner_pkg::DUCK_H;
      end else begin
        sprite_kind[0] <= runner_pkg::KIND_RUNNER;
        sprite_y[0]    <= runner_y - runner_pkg::RUNNER_H;
      end
      // obstacle slot i lands in sprite slot i+1
      for (int i = 0; i < OBSTACLE_SLOTS; i++) begin
        if (obst_live[i]) begin
          sprite_kind[i+1] <= runner_pkg::KIND_CACTUS;
          sprite_x[i+1]    <= obst_x[i];
          sprite_y[i+1]    <= CACTUS_Y;
        end else begin
          sprite_kind[i+1] <= runner_pkg::KIND_NONE;
          sprite_x[i+1]    <= '0;
          sprite_y[i+1]    <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/runner_top.sv
`timescale 1ns/1ps
`default_nettype none

module runner_top #(
  parameter int OBSTACLE_SLOTS = 3,
  parameter int SCROLL_SPEED = 4,
  localparam int RENDER_SLOTS = OBSTACLE_SLOTS + 1
) (
  input  logic                                          clk_33m,
  input  logic                                          arst_n,
  input  logic                                          jumping,
  input  logic                                          ducking,
  input  logic                                          slow,
  input  runner_pkg::seed_t                             random_seed,
  input  logic                                          sprite_ready,
  output logic                                          sprite_valid,
  output runner_pkg::sprite_kind_t [RENDER_SLOTS-1:0]   sprite_kind,
  output runner_pkg::coord_t [RENDER_SLOTS-1:0]         sprite_x,
  output runner_pkg::coord_t [RENDER_SLOTS-1:0]         sprite_y,
  output runner_pkg::score_t                            score,
  output runner_pkg::game_state_t                       game_state
);

  logic                                    step;
  logic                                    list_load;
  logic                                    restart;
  logic                                    running;
  logic                                    hit;
  runner_pkg::coord_t                      runner_y;
  logic                                    crouched;
  logic [OBSTACLE_SLOTS-1:0]               obst_live;
  runner_pkg::coord_t [OBSTACLE_SLOTS-1:0] obst_x;

  // datapaths only move while a run is in progress
  assign running = (game_state == runner_pkg::game_run);

  runner_ctrl i_ctrl (
    .clk_33m      (clk_33m),
    .arst_n       (arst_n),
    .jumping      (jumping),
    .hit          (hit),
    .sprite_ready (sprite_ready),
    .step         (step),
    .list_load    (list_load),
    .sprite_valid (sprite_valid),
    .restart      (restart),
    .state        (game_state),
    .score        (score)
  );

  player_physics i_physics (
    .clk_33m  (clk_33m),
    .arst_n   (arst_n),
    .step     (step),
    .running  (running),
    .restart  (restart),
    .jumping  (jumping),
    .ducking  (ducking),
    .runner_y (runner_y),
    .crouched (crouched)
  );

  obstacle_field #(
    .OBSTACLE_SLOTS (OBSTACLE_SLOTS),
    .SCROLL_SPEED   (SCROLL_SPEED)
  ) i_obstacles (
    .clk_33m     (clk_33m),
    .arst_n      (arst_n),
    .step        (step),
    .running     (running),
    .restart     (restart),
    .slow        (slow),
    .random_seed (random_seed),
    .obst_live   (obst_live),
    .obst_x      (obst_x)
  );

  collision_check #(
    .OBSTACLE_SLOTS (OBSTACLE_SLOTS)
  ) i_collision (
    .runner_y  (runner_y),
    .crouched  (crouched),
    .obst_live (obst_live),
    .obst_x    (obst_x),
    .hit       (hit)
  );

  sprite_list #(
    .OBSTACLE_SLOTS (OBSTACLE_SLOTS)
  ) i_sprites (
    .clk_33m     (clk_33m),
    .arst_n      (arst_n),
    .list_load   (list_load),
    .runner_y    (runner_y),
    .crouched    (crouched),
    .obst_live   (obst_live),
    .obst_x      (obst_x),
    .sprite_kind (sprite_kind),
    .sprite_x    (sprite_x),
    .sprite_y    (sprite_y)
  );

endmodule

`default_nettype wire

//--- tests/tb_runner_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_runner_top;

  localparam int SLOTS = 3;
  localparam int SPEED = 4;
  localparam int RENDER_SLOTS = SLOTS + 1;
  // steps issued by all tasks, collision loop counted at its bound
  localparam int TOTAL_STEPS = 740;
  localparam int CYCLE_LIMIT = 4 * (TOTAL_STEPS + 20);

  logic                                          clk_33m;
  logic                                          arst_n;
  logic                                          jumping;
  logic                                          ducking;
  logic                                          slow;
  runner_pkg::seed_t                             random_seed;
  logic                                          sprite_ready;
  logic                                          sprite_valid;
  runner_pkg::sprite_kind_t [RENDER_SLOTS-1:0]   sprite_kind;
  runner_pkg::coord_t [RENDER_SLOTS-1:0]         sprite_x;
  runner_pkg::coord_t [RENDER_SLOTS-1:0]         sprite_y;
  runner_pkg::score_t                            score;
  runner_pkg::game_state_t                       game_state;

  integer seed;
  int     errors;
  int     checks;
  int     cycles;
  // painter mode, random ready when set
  logic   rand_ready;

  // reference model of the game, one update per accepted list
  runner_pkg::game_state_t m_state;
  int                      m_height;
  int                      m_vel;
  logic                    m_crouch;
  logic [SLOTS-1:0]        m_live;
  int                      m_x [SLOTS];
  int                      m_count;
  runner_pkg::seed_t       m_lfsr;
  logic                    m_half;
  int                      m_score;

  runner_top #(
    .OBSTACLE_SLOTS (SLOTS),
    .SCROLL_SPEED   (SPEED)
  ) i_dut (
    .clk_33m      (clk_33m),
    .arst_n       (arst_n),
    .jumping      (jumping),
    .ducking      (ducking),
    .slow         (slow),
    .random_seed  (random_seed),
    .sprite_ready (sprite_ready),
    .sprite_valid (sprite_valid),
    .sprite_kind  (sprite_kind),
    .sprite_x     (sprite_x),
    .sprite_y     (sprite_y),
    .score        (score),
    .game_state   (game_state)
  );

  initial begin
    clk_33m = 1'b0;
    forever #2 clk_33m = ~clk_33m;
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_33m);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic model_reset();
    m_state  = runner_pkg::game_idle;
    m_height = 0;
    m_vel    = 0;
    m_crouch = 1'b0;
    m_live   = '0;
    m_score  = 0;
    m_half   = 1'b0;
  endtask

  // overlap of the shown runner box with any live cactus, half-open boxes
  function automatic logic model_hit();
    int   feet;
    int   top;
    logic hit;
    feet = int'(runner_pkg::GROUND_Y) - m_height;
    top = feet - (m_crouch ? int'(runner_pkg::DUCK_H) : int'(runner_pkg::RUNNER_H));
    hit = 1'b0;
    for (int i = 0; i < SLOTS; i++) begin
      if (m_live[i] && top < int'(runner_pkg::GROUND_Y) &&
          feet > int'(runner_pkg::GROUND_Y - runner_pkg::CACTUS_H) &&
          m_x[i] < int'(runner_pkg::RUNNER_X + runner_pkg::RUNNER_W) &&
          m_x[i] + int'(runner_pkg::CACTUS_W) > int'(runner_pkg::RUNNER_X)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic model_accept(input logic j, input logic d, input logic s);
    int   v;
    int   nh;
    logic move;
    logic placed;
    if (m_state == runner_pkg::game_run) begin
      if (model_hit()) begin
        // frozen, the step that follows changes nothing
        m_state = runner_pkg::game_over;
      end else begin
        m_score++;
        if (m_height != 0 || j) begin
          v = (m_height == 0 && j) ? int'(runner_pkg::JUMP_V) : m_vel;
          nh = m_height + v;
          if (nh <= 0) begin
            m_height = 0;
            m_vel    = 0;
            m_crouch = d;
          end else begin
            m_height = nh;
            m_vel    = v - int'(runner_pkg::GRAVITY);
            m_crouch = 1'b0;
          end
        end else begin
          m_crouch = d;
        end
        // scroll, half rate while slow
        move = !s || m_half;
        if (s) begin
          m_half = !m_half;
        end
        for (int i = 0; i < SLOTS; i++) begin
          if (m_live[i] && move) begin
            if (m_x[i] < SPEED) begin
              m_live[i] = 1'b0;
            end else begin
              m_x[i] = m_x[i] - SPEED;
            end
          end
        end
        // spawn countdown and lfsr gap
        m_count--;
        if (m_count == 0) begin
          placed = 1'b0;
          for (int i = 0; i < SLOTS; i++) begin
            if (!m_live[i] && !placed) begin
              m_live[i] = 1'b1;
              m_x[i]    = int'(runner_pkg::SCREEN_W);
              placed    = 1'b1;
            end
          end
          m_count = runner_pkg::MIN_GAP + int'(m_lfsr[4:0]);
          m_lfsr = {m_lfsr[9:0], m_lfsr[10] ^ m_lfsr[8]};
        end
      end
    end else if (j) begin
      // restart step, nothing moves yet
      model_reset();
      m_state = runner_pkg::game_run;
      m_count = runner_pkg::MIN_GAP;
      m_lfsr  = (random_seed == '0) ? 11'd1 : random_seed;
    end
  endtask

  task automatic compare_list();
    int feet;
    feet = int'(runner_pkg::GROUND_Y) - m_height;
    check_value("sprite_kind[0]", sprite_kind[0],
                m_crouch ? runner_pkg::KIND_RUNNER_DUCK : runner_pkg::KIND_RUNNER);
    check_value("sprite_x[0]", sprite_x[0], runner_pkg::RUNNER_X);
    check_value("sprite_y[0]", sprite_y[0],
                feet - (m_crouch ? int'(runner_pkg::DUCK_H) : int'(runner_pkg::RUNNER_H)));
    for (int i = 0; i < SLOTS; i++) begin
      check_value($sformatf("sprite_kind[%0d]", i + 1), sprite_kind[i+1],
                  m_live[i] ? runner_pkg::KIND_CACTUS : runner_pkg::KIND_NONE);
      if (m_live[i]) begin
        check_value($sformatf("sprite_x[%0d]", i + 1), sprite_x[i+1], m_x[i]);
        check_value($sformatf("sprite_y[%0d]", i + 1), sprite_y[i+1],
                    runner_pkg::GROUND_Y - runner_pkg::CACTUS_H);
      end
    end
  endtask

  task automatic reset_dut();
    @(posedge clk_33m);
    arst_n       <= 1'b0;
    sprite_ready <= 1'b0;
    jumping      <= 1'b0;
    ducking      <= 1'b0;
    slow         <= 1'b0;
    repeat (3) @(posedge clk_33m);
    arst_n <= 1'b1;
    model_reset();
    // valid rises on the second edge after release
    @(negedge clk_33m);
    check_value("sprite_valid", sprite_valid, 0);
    @(negedge clk_33m);
    check_value("sprite_valid", sprite_valid, 0);
    @(negedge clk_33m);
    check_value("sprite_valid", sprite_valid, 1);
    compare_list();
    check_value("score", score, 0);
    check_value("game_state", game_state, runner_pkg::game_idle);
  endtask

  // painter side of one accepted list
  task automatic do_step(input logic j, input logic d, input logic s);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk_33m);
      jumping      <= j;
      ducking      <= d;
      slow         <= s;
      sprite_ready <= rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk_33m);
      // list must hold while valid waits
      compare_list();
      accepted = sprite_valid && sprite_ready;
    end
    @(posedge clk_33m);
    sprite_ready <= 1'b0;
    @(negedge clk_33m);
    check_value("sprite_valid", sprite_valid, 0);
    compare_list();
    @(negedge clk_33m);
    check_value("sprite_valid", sprite_valid, 0);
    compare_list();
    model_accept(j, d, s);
    // new list exactly 3 cycles after the accept
    @(negedge clk_33m);
    check_value("sprite_valid", sprite_valid, 1);
    compare_list();
    check_value("score", score, m_score);
    check_value("game_state", game_state, m_state);
  endtask

  // hop any cactus entering the window ahead of the runner
  function automatic logic should_jump(input logic s);
    int   hi;
    logic j;
    hi = s ? 72 : 124;
    j = 1'b0;
    if (m_height == 0) begin
      for (int i = 0; i < SLOTS; i++) begin
        if (m_live[i] && m_x[i] >= 60 && m_x[i] <= hi) begin
          j = 1'b1;
        end
      end
    end
    return j;
  endfunction

  task automatic run_steps(input int n, input logic auto_jump, input logic s);
    for (int k = 0; k < n; k++) begin
      do_step(auto_jump && should_jump(s), 1'b0, s);
    end
  endtask

  task automatic reset_and_idle();
    reset_dut();
    // duck alone in idle moves nothing
    repeat (4) do_step(1'b0, 1'b1, 1'b0);
    check_value("score", score, 0);
  endtask

  task automatic jump_arc();
    do_step(1'b1, 1'b0, 1'b0);
    check_value("game_state", game_state, runner_pkg::game_run);
    // take off, then free flight
    do_step(1'b1, 1'b0, 1'b0);
    repeat (24) do_step(1'b0, 1'b0, 1'b0);
    check_value("sprite_y[0]", sprite_y[0], runner_pkg::GROUND_Y - runner_pkg::RUNNER_H);
    do_step(1'b0, 1'b1, 1'b0);
    check_value("sprite_kind[0]", sprite_kind[0], runner_pkg::KIND_RUNNER_DUCK);
    do_step(1'b0, 1'b1, 1'b0);
    do_step(1'b0, 1'b0, 1'b0);
    check_value("sprite_kind[0]", sprite_kind[0], runner_pkg::KIND_RUNNER);
  endtask

  task automatic spawn_and_scroll();
    int start;
    start = m_score;
    run_steps(140, 1'b1, 1'b0);
    if (m_state == runner_pkg::game_run) begin
      check_value("score", score, start + 140);
    end
    // half-rate scroll
    run_steps(60, 1'b1, 1'b1);
  endtask

  task automatic back_pressure();
    // a run lost in the slow phase starts over so the list keeps changing
    if (m_state != runner_pkg::game_run) begin
      do_step(1'b1, 1'b0, 1'b0);
    end
    rand_ready = 1'b1;
    run_steps(40, 1'b1, 1'b0);
    rand_ready = 1'b0;
  endtask

  task automatic collision_and_restart();
    int n;
    n = 0;
    while (m_state == runner_pkg::game_run && n < 300) begin
      do_step(1'b0, 1'b0, 1'b0);
      n++;
    end
    check_value("game_state", game_state, runner_pkg::game_over);
    repeat (3) do_step(1'b0, 1'b0, 1'b0);
    @(posedge clk_33m);
    random_seed <= 11'h5a3;
    do_step(1'b1, 1'b0, 1'b0);
    check_value("score", score, 0);
    for (int i = 1; i < RENDER_SLOTS; i++) begin
      check_value($sformatf("sprite_kind[%0d]", i), sprite_kind[i], runner_pkg::KIND_NONE);
    end
    // first spawns after the reseed
    run_steps(80, 1'b0, 1'b0);
  endtask

  task automatic zero_seed();
    reset_dut();
    @(posedge clk_33m);
    random_seed <= '0;
    do_step(1'b1, 1'b0, 1'b0);
    run_steps(80, 1'b0, 1'b0);
  endtask

  initial begin
    arst_n       = 1'b0;
    jumping      = 1'b0;
    ducking      = 1'b0;
    slow         = 1'b0;
    random_seed  = 11'h2c5;
    sprite_ready = 1'b0;
    rand_ready   = 1'b0;
    seed         = 32'he11f;
    errors       = 0;
    checks       = 0;
    model_reset();
    reset_and_idle();
    jump_arc();
    spawn_and_scroll();
    back_pressure();
    collision_and_restart();
    zero_seed();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hw/runner_pkg.sv
hw/runner_ctrl.sv
hw/player_physics.sv
hw/obstacle_field.sv
hw/collision_check.sv
hw/sprite_list.sv
hw/runner_top.sv
tests/tb_runner_top.sv

//--- Makefile
TOP = tb_runner_top

all: run

build:
	verilator --binary --timing -f files.f --top-module $(TOP) -o sim_runner

run: build
	@out=$$(./obj_dir/sim_runner); echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module runner_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
